/* Makefile */
# Verilator build and run of the MIPS execute core testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail on errors"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module mipsCoreTb -Mdir obj_dir -f flist.f
	./obj_dir/VmipsCoreTb +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "FAIL: no result in $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

/* flist.f */
logic/cpuPkg.sv
logic/datapathController.sv
logic/registerFile.sv
logic/alu.sv
logic/executeStage.sv
logic/mipsCore.sv
testbench/mipsCore_properties.sv
testbench/mipsCoreTb.sv

/* logic/alu.sv */
`default_nettype none

module alu (
    input  cpuPkg::aluOpT AluOp,
    input  logic [5:0]    Funct,
    input  logic [4:0]    Shamt,
    input  cpuPkg::wordT  A,
    input  cpuPkg::wordT  B,
    output cpuPkg::wordT  Result
);

    cpuPkg::wordT sum;
    cpuPkg::wordT diff;
    cpuPkg::wordT product;
    logic         ltSigned;
    logic         ltUnsigned;

    // Shared arithmetic
    assign sum        = A + B;
    assign diff       = A - B;
    assign product    = A * B;  // Low word only
    assign ltSigned   = $signed(A) < $signed(B);
    assign ltUnsigned = A < B;

    //////////////////////////////////////////////////
    // Operation select
    //////////////////////////////////////////////////
    always_comb begin
        Result = '0;
        case (AluOp)
            cpuPkg::AluAdd, cpuPkg::AluAddu: Result = sum;
            cpuPkg::AluAnd:                  Result = A & B;
            cpuPkg::AluOr:                   Result = A | B;
            cpuPkg::AluXor:                  Result = A ^ B;
            cpuPkg::AluSlt:                  Result = {31'b0, ltSigned};
            cpuPkg::AluSltu:                 Result = {31'b0, ltUnsigned};

            cpuPkg::AluRType: begin
                case (Funct)
                    cpuPkg::FnAdd, cpuPkg::FnAddu: Result = sum;
                    cpuPkg::FnSub, cpuPkg::FnSubu: Result = diff;
                    cpuPkg::FnAnd:  Result = A & B;
                    cpuPkg::FnOr:   Result = A | B;
                    cpuPkg::FnXor:  Result = A ^ B;
                    cpuPkg::FnNor:  Result = ~(A | B);
                    cpuPkg::FnSlt:  Result = {31'b0, ltSigned};
                    cpuPkg::FnSltu: Result = {31'b0, ltUnsigned};
                    cpuPkg::FnSll:  Result = B << Shamt;  // Shifts act on rt
                    cpuPkg::FnSrl:  Result = B >> Shamt;
                    default:        Result = '0;
                endcase
            end

            cpuPkg::AluSpecial2: begin
                if (Funct == cpuPkg::FnMul) begin
                    Result = product;
                end
            end

            cpuPkg::AluSpecial3: begin
                // Byte or half-word sign extension of rt
                if (Funct == cpuPkg::FnBshfl) begin
                    case (Shamt)
                        cpuPkg::SelSeb: Result = {{24{B[7]}}, B[7:0]};
                        cpuPkg::SelSeh: Result = {{16{B[15]}}, B[15:0]};
                        default:        Result = '0;
                    endcase
                end
            end

            default: Result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    //////////////////////////////////////////////////
    // Basic widths
    //////////////////////////////////////////////////
    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIdxT;
    typedef logic [31:0] instrT;
    typedef logic [5:0]  opCodeT;

    // Main decoder ALU operation encodings
    typedef enum logic [3:0] {
        AluRType    = 4'b0000,
        AluAdd      = 4'b0001,
        AluOr       = 4'b0011,
        AluAnd      = 4'b0100,
        AluXor      = 4'b0101,
        AluAddu     = 4'b0111,
        AluSlt      = 4'b1010,
        AluSltu     = 4'b1011,
        AluSpecial2 = 4'b1100,
        AluSpecial3 = 4'b1101
    } aluOpT;

    // All zero means no operation
    typedef struct packed {
        logic  regDst;   // Dest is rd instead of rt
        logic  regWrite;
        logic  aluSrc;   // Operand B from immediate
        logic  signExt;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        regIdxT dest;
        wordT   data;
    } wbT;

    //////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////
    localparam opCodeT OpRType    = 6'b000000;
    localparam opCodeT OpSpecial2 = 6'b011100;  // mul
    localparam opCodeT OpSpecial3 = 6'b011111;  // seb, seh
    localparam opCodeT OpAddi     = 6'b001000;
    localparam opCodeT OpAddiu    = 6'b001001;
    localparam opCodeT OpSlti     = 6'b001010;
    localparam opCodeT OpSltiu    = 6'b001011;
    localparam opCodeT OpAndi     = 6'b001100;
    localparam opCodeT OpOri      = 6'b001101;
    localparam opCodeT OpXori     = 6'b001110;
    localparam opCodeT OpIdle     = 6'b111111;  // Controller state with nothing accepted

    //////////////////////////////////////////////////
    // Function fields
    //////////////////////////////////////////////////
    localparam logic [5:0] FnSll   = 6'b000000;
    localparam logic [5:0] FnSrl   = 6'b000010;
    localparam logic [5:0] FnAdd   = 6'b100000;
    localparam logic [5:0] FnAddu  = 6'b100001;
    localparam logic [5:0] FnSub   = 6'b100010;
    localparam logic [5:0] FnSubu  = 6'b100011;
    localparam logic [5:0] FnAnd   = 6'b100100;
    localparam logic [5:0] FnOr    = 6'b100101;
    localparam logic [5:0] FnXor   = 6'b100110;
    localparam logic [5:0] FnNor   = 6'b100111;
    localparam logic [5:0] FnSlt   = 6'b101010;
    localparam logic [5:0] FnSltu  = 6'b101011;
    localparam logic [5:0] FnMul   = 6'b000010;  // Special2 group
    localparam logic [5:0] FnBshfl = 6'b100000;  // Special3 group

    // Shamt field picks the bshfl variant
    localparam logic [4:0] SelSeb = 5'b10000;
    localparam logic [4:0] SelSeh = 5'b11000;

endpackage

`default_nettype wire

/* logic/datapathController.sv */
`default_nettype none

module datapathController (
    input  logic           Clk,
    input  logic           Rst,
    input  logic           InstrValid,
    input  cpuPkg::opCodeT OpCode,
    output cpuPkg::ctrlT   Ctrl
);

    cpuPkg::opCodeT state;

    //////////////////////////////////////////////////
    // State register
    //////////////////////////////////////////////////
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            state <= cpuPkg::OpIdle;
        end else if (InstrValid) begin
            state <= OpCode;          // Last accepted opcode
        end else begin
            state <= cpuPkg::OpIdle;  // Gap in the stream
        end
    end

    //////////////////////////////////////////////////
    // Output decode
    //////////////////////////////////////////////////
    always_comb begin
        Ctrl = '0;
        case (state)
            cpuPkg::OpIdle: begin
                Ctrl = '0;
            end
            cpuPkg::OpRType: begin
                Ctrl.regDst   = 1'b1;
                Ctrl.regWrite = 1'b1;
                Ctrl.aluOp    = cpuPkg::AluRType;
            end
            cpuPkg::OpSpecial2: begin
                Ctrl.regDst   = 1'b1;
                Ctrl.regWrite = 1'b1;
                Ctrl.aluOp    = cpuPkg::AluSpecial2;
            end
            cpuPkg::OpSpecial3: begin
                Ctrl.regDst   = 1'b1;  // seb and seh write rd
                Ctrl.regWrite = 1'b1;
                Ctrl.aluOp    = cpuPkg::AluSpecial3;
            end
            cpuPkg::OpAddi, cpuPkg::OpAddiu: begin
                Ctrl.regWrite = 1'b1;
                Ctrl.aluSrc   = 1'b1;
                Ctrl.signExt  = 1'b1;
                // No overflow trap, so both behave the same
                Ctrl.aluOp    = (state == cpuPkg::OpAddi) ? cpuPkg::AluAdd : cpuPkg::AluAddu;
            end
            cpuPkg::OpSlti, cpuPkg::OpSltiu: begin
                Ctrl.regWrite = 1'b1;
                Ctrl.aluSrc   = 1'b1;
                Ctrl.signExt  = 1'b1;  // sltiu still sign-extends
                Ctrl.aluOp    = (state == cpuPkg::OpSlti) ? cpuPkg::AluSlt : cpuPkg::AluSltu;
            end
            cpuPkg::OpAndi: begin
                Ctrl.regWrite = 1'b1;
                Ctrl.aluSrc   = 1'b1;
                Ctrl.aluOp    = cpuPkg::AluAnd;
            end
            cpuPkg::OpOri: begin
                Ctrl.regWrite = 1'b1;
                Ctrl.aluSrc   = 1'b1;
                Ctrl.aluOp    = cpuPkg::AluOr;
            end
            cpuPkg::OpXori: begin
                Ctrl.regWrite = 1'b1;
                Ctrl.aluSrc   = 1'b1;
                Ctrl.aluOp    = cpuPkg::AluXor;
            end
            default: begin
                Ctrl = '0;  // Unknown opcode writes nothing
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/executeStage.sv */
`default_nettype none

module executeStage (
    input  logic           Clk,
    input  logic           Rst,
    input  logic           InstrValid,
    input  cpuPkg::instrT  Instr,
    input  cpuPkg::ctrlT   Ctrl,
    output cpuPkg::regIdxT RsAddr,
    output cpuPkg::regIdxT RtAddr,
    input  cpuPkg::wordT   RsData,
    input  cpuPkg::wordT   RtData,
    output logic           WrEn,
    output cpuPkg::wbT     WrBack
);

    cpuPkg::instrT  instrReg;
    logic           pending;
    cpuPkg::wordT   immExt;
    cpuPkg::wordT   operandB;
    cpuPkg::wordT   aluResult;
    cpuPkg::regIdxT dest;

    //////////////////////////////////////////////////
    // Instruction register
    //////////////////////////////////////////////////
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            pending <= 1'b0;
        end else begin
            pending <= InstrValid;  // Same edge as the controller state
        end
    end

    always_ff @(posedge Clk) begin
        if (InstrValid) begin
            instrReg <= Instr;
        end
    end

    assign RsAddr = instrReg[25:21];
    assign RtAddr = instrReg[20:16];

    // Logical immediates zero-extend
    assign immExt = Ctrl.signExt ? {{16{instrReg[15]}}, instrReg[15:0]}
                                 : {16'b0, instrReg[15:0]};

    // Shifts and seb/seh keep aluSrc low, so B carries rt
    assign operandB = Ctrl.aluSrc ? immExt : RtData;

    alu aluInst (
        .AluOp  (Ctrl.aluOp),
        .Funct  (instrReg[5:0]),
        .Shamt  (instrReg[10:6]),
        .A      (RsData),
        .B      (operandB),
        .Result (aluResult)
    );

    //////////////////////////////////////////////////
    // Writeback
    //////////////////////////////////////////////////
    assign dest = Ctrl.regDst ? instrReg[15:11] : instrReg[20:16];

    assign WrEn        = pending & Ctrl.regWrite & (dest != '0);  // Never strobe r0
    assign WrBack.dest = dest;
    assign WrBack.data = aluResult;

endmodule

`default_nettype wire

/* logic/mipsCore.sv */
`default_nettype none

module mipsCore (
    input  logic          Clk,
    input  logic          Rst,
    input  logic          InstrValid,
    input  cpuPkg::instrT Instr,
    output logic          WbValid,
    output cpuPkg::wbT    Wb
);

    cpuPkg::ctrlT   ctrl;
    cpuPkg::regIdxT rsAddr;
    cpuPkg::regIdxT rtAddr;
    cpuPkg::wordT   rsData;
    cpuPkg::wordT   rtData;

    datapathController ctrlInst (
        .Clk        (Clk),
        .Rst        (Rst),
        .InstrValid (InstrValid),
        .OpCode     (Instr[31:26]),  // Opcode field
        .Ctrl       (ctrl)
    );

    executeStage exInst (
        .Clk        (Clk),
        .Rst        (Rst),
        .InstrValid (InstrValid),
        .Instr      (Instr),
        .Ctrl       (ctrl),
        .RsAddr     (rsAddr),
        .RtAddr     (rtAddr),
        .RsData     (rsData),
        .RtData     (rtData),
        .WrEn       (WbValid),
        .WrBack     (Wb)
    );

    // Write port shares the external writeback
    registerFile rfInst (
        .Clk    (Clk),
        .Rst    (Rst),
        .RsAddr (rsAddr),
        .RtAddr (rtAddr),
        .RsData (rsData),
        .RtData (rtData),
        .WrEn   (WbValid),
        .WrBack (Wb)
    );

endmodule

`default_nettype wire

/* logic/registerFile.sv */
`default_nettype none

module registerFile (
    input  logic           Clk,
    input  logic           Rst,
    input  cpuPkg::regIdxT RsAddr,
    input  cpuPkg::regIdxT RtAddr,
    output cpuPkg::wordT   RsData,
    output cpuPkg::wordT   RtData,
    input  logic           WrEn,
    input  cpuPkg::wbT     WrBack
);

    cpuPkg::wordT regMem [32];

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            for (int i = 0; i < 32; i++) begin
                regMem[i] <= '0;
            end
        end else if (WrEn && (WrBack.dest != '0)) begin
            // Register 0 is never written
            regMem[WrBack.dest] <= WrBack.data;
        end
    end

    // Read ports need no bypass
    // Writes land at the edge before the next read
    assign RsData = regMem[RsAddr];
    assign RtData = regMem[RtAddr];

endmodule

`default_nettype wire

/* testbench/mipsCoreTb.sv */
`default_nettype none

module mipsCoreTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NumRandom = 400;
    localparam int MaxCycles = 2 * (NumRandom + 80) + 50;  // One gap per instruction at most

    localparam logic [5:0] RFuncts [12] = '{
        cpuPkg::FnAdd, cpuPkg::FnAddu, cpuPkg::FnSub, cpuPkg::FnSubu,
        cpuPkg::FnAnd, cpuPkg::FnOr, cpuPkg::FnXor, cpuPkg::FnNor,
        cpuPkg::FnSlt, cpuPkg::FnSltu, cpuPkg::FnSll, cpuPkg::FnSrl};
    localparam cpuPkg::opCodeT ImmOps [7] = '{
        cpuPkg::OpAddi, cpuPkg::OpAddiu, cpuPkg::OpSlti, cpuPkg::OpSltiu,
        cpuPkg::OpAndi, cpuPkg::OpOri, cpuPkg::OpXori};

    logic          Clk;
    logic          Rst;
    logic          InstrValid;
    cpuPkg::instrT Instr;
    logic          WbValid;
    cpuPkg::wbT    Wb;

    cpuPkg::wordT  refRegs [32];  // Reference register model
    cpuPkg::wbT    expQ [$];
    cpuPkg::wbT    expWb;
    int            checks = 0;
    int            errors = 0;

    mipsCore UUT (.Clk, .Rst, .InstrValid, .Instr, .WbValid, .Wb);

    initial Clk = 1'b0;
    always #5 Clk = ~Clk;

    function automatic cpuPkg::instrT makeInstr(cpuPkg::opCodeT op, cpuPkg::regIdxT rs,
                                                cpuPkg::regIdxT rt, logic [15:0] low);
        return {op, rs, rt, low};  // low is the immediate or {rd, shamt, funct}
    endfunction

    function automatic logic isKnown(cpuPkg::opCodeT op);
        return op inside {cpuPkg::OpRType, cpuPkg::OpSpecial2, cpuPkg::OpSpecial3,
                          cpuPkg::OpAddi, cpuPkg::OpAddiu, cpuPkg::OpSlti, cpuPkg::OpSltiu,
                          cpuPkg::OpAndi, cpuPkg::OpOri, cpuPkg::OpXori};
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    task automatic predict(input cpuPkg::instrT ins);
        cpuPkg::wordT   a;
        cpuPkg::wordT   b;
        cpuPkg::wordT   sImm;
        cpuPkg::wordT   zImm;
        cpuPkg::wordT   res;
        cpuPkg::regIdxT dest;
        cpuPkg::wbT     entry;
        logic [5:0]     fn;
        logic [4:0]     sa;
        logic           writes;
        a      = refRegs[ins[25:21]];
        b      = refRegs[ins[20:16]];
        sImm   = {{16{ins[15]}}, ins[15:0]};
        zImm   = {16'b0, ins[15:0]};
        fn     = ins[5:0];
        sa     = ins[10:6];
        res    = '0;
        writes = 1'b1;
        dest   = ins[20:16];
        case (ins[31:26])
            cpuPkg::OpRType: begin
                dest = ins[15:11];
                case (fn)
                    cpuPkg::FnAdd, cpuPkg::FnAddu: res = a + b;
                    cpuPkg::FnSub, cpuPkg::FnSubu: res = a - b;
                    cpuPkg::FnAnd:  res = a & b;
                    cpuPkg::FnOr:   res = a | b;
                    cpuPkg::FnXor:  res = a ^ b;
                    cpuPkg::FnNor:  res = ~(a | b);
                    cpuPkg::FnSlt:  res = {31'b0, $signed(a) < $signed(b)};
                    cpuPkg::FnSltu: res = {31'b0, a < b};
                    cpuPkg::FnSll:  res = b << sa;
                    cpuPkg::FnSrl:  res = b >> sa;
                    default:        res = '0;
                endcase
            end
            cpuPkg::OpSpecial2: begin
                dest = ins[15:11];
                res  = (fn == cpuPkg::FnMul) ? a * b : '0;
            end
            cpuPkg::OpSpecial3: begin
                dest = ins[15:11];
                if (fn == cpuPkg::FnBshfl && sa == cpuPkg::SelSeb) begin
                    res = {{24{b[7]}}, b[7:0]};
                end else if (fn == cpuPkg::FnBshfl && sa == cpuPkg::SelSeh) begin
                    res = {{16{b[15]}}, b[15:0]};
                end
            end
            cpuPkg::OpAddi, cpuPkg::OpAddiu: res = a + sImm;  // No overflow trap
            cpuPkg::OpSlti:  res = {31'b0, $signed(a) < $signed(sImm)};
            cpuPkg::OpSltiu: res = {31'b0, a < sImm};
            cpuPkg::OpAndi:  res = a & zImm;
            cpuPkg::OpOri:   res = a | zImm;
            cpuPkg::OpXori:  res = a ^ zImm;
            default:         writes = 1'b0;
        endcase
        if (writes && dest != '0) begin
            refRegs[dest] = res;
            entry.dest    = dest;
            entry.data    = res;
            expQ.push_back(entry);
        end
    endtask

    // Strobes one instruction 1 ns after a rising edge
    task automatic send(input cpuPkg::instrT ins);
        InstrValid = 1'b1;
        Instr      = ins;
        predict(ins);
        @(posedge Clk);
        #1;
        InstrValid = 1'b0;
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(posedge Clk);
        #1;
    endtask

    function automatic cpuPkg::instrT randomInstr();
        cpuPkg::regIdxT rs;
        cpuPkg::regIdxT rt;
        cpuPkg::regIdxT rd;
        cpuPkg::opCodeT op;
        logic [4:0]     sel;
        int             kind;
        rs   = 5'($urandom);
        rt   = 5'($urandom);
        rd   = 5'($urandom);
        sel  = ($urandom_range(0, 1) == 0) ? cpuPkg::SelSeb : cpuPkg::SelSeh;
        kind = $urandom_range(0, 9);
        if (kind < 4) begin
            return makeInstr(cpuPkg::OpRType, rs, rt,
                             {rd, 5'($urandom), RFuncts[4'($urandom_range(0, 11))]});
        end else if (kind == 4) begin
            return makeInstr(cpuPkg::OpSpecial2, rs, rt, {rd, 5'd0, cpuPkg::FnMul});
        end else if (kind == 5) begin
            return makeInstr(cpuPkg::OpSpecial3, rs, rt, {rd, sel, cpuPkg::FnBshfl});
        end else if (kind < 9) begin
            return makeInstr(ImmOps[3'($urandom_range(0, 6))], rs, rt, 16'($urandom));
        end
        do begin
            op = 6'($urandom);
        end while (isKnown(op));
        return {op, 26'($urandom)};  // Must write nothing
    endfunction

    //////////////////////////////////////////////////
    // Writeback check at the falling edge
    //////////////////////////////////////////////////
    always @(negedge Clk) begin
        if (WbValid) begin
            checks++;
            if (expQ.size() == 0) begin
                errors++;
                $display("** Error at %0t: unexpected write r%0d=%h", $time, Wb.dest, Wb.data);
            end else begin
                expWb = expQ.pop_front();
                assert (Wb == expWb) else begin
                    errors++;
                    $display("** Error at %0t: write r%0d=%h, expected r%0d=%h",
                             $time, Wb.dest, Wb.data, expWb.dest, expWb.data);
                end
            end
        end
    end

    initial begin
        #(MaxCycles * 10);
        $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
        $display("Errors found");
        $finish;
    end

    initial begin
        void'($urandom(32'hb8b7_471a));
        foreach (refRegs[i]) begin
            refRegs[i] = '0;
        end
        Rst        = 1'b1;
        InstrValid = 1'b0;
        Instr      = '0;
        repeat (5) @(posedge Clk);
        #1;
        Rst = 1'b0;

        // Directed loads through ori leave the upper half zero
        for (int r = 1; r < 32; r++) begin
            send(makeInstr(cpuPkg::OpOri, 5'd0, 5'(r), 16'($urandom)));
        end
        send(makeInstr(cpuPkg::OpAddiu, 5'd1, 5'd2, 16'hff80));
        send(makeInstr(cpuPkg::OpAddi, 5'd3, 5'd4, 16'h8001));
        send(makeInstr(cpuPkg::OpSlti, 5'd2, 5'd9, 16'hffff));
        send(makeInstr(cpuPkg::OpSltiu, 5'd2, 5'd10, 16'hfff0));
        send(makeInstr(cpuPkg::OpAndi, 5'd2, 5'd11, 16'hf0f0));  // Zero-extended
        send(makeInstr(cpuPkg::OpXori, 5'd4, 5'd12, 16'h8000));
        send(makeInstr(cpuPkg::OpOri, 5'd4, 5'd13, 16'hc000));
        for (int f = 0; f < 12; f++) begin
            send(makeInstr(cpuPkg::OpRType, 5'd2, 5'd4, {5'(f + 14), 5'd3, RFuncts[f]}));
        end
        send(makeInstr(cpuPkg::OpSpecial2, 5'd2, 5'd4, {5'd26, 5'd0, cpuPkg::FnMul}));
        send(makeInstr(cpuPkg::OpSpecial3, 5'd0, 5'd2, {5'd27, cpuPkg::SelSeb, cpuPkg::FnBshfl}));
        send(makeInstr(cpuPkg::OpSpecial3, 5'd0, 5'd4, {5'd28, cpuPkg::SelSeh, cpuPkg::FnBshfl}));

        // Dependent pair back to back and an r0 write then read
        send(makeInstr(cpuPkg::OpAddiu, 5'd0, 5'd5, 16'hfff0));
        send(makeInstr(cpuPkg::OpRType, 5'd5, 5'd5, {5'd6, 5'd0, cpuPkg::FnAdd}));
        send(makeInstr(cpuPkg::OpOri, 5'd0, 5'd0, 16'hffff));
        send(makeInstr(cpuPkg::OpRType, 5'd0, 5'd6, {5'd7, 5'd0, cpuPkg::FnOr}));

        for (int n = 0; n < NumRandom; n++) begin
            send(randomInstr());
            if ($urandom_range(0, 3) == 0) begin
                waitCycles(1);
            end
        end
        waitCycles(4);

        if (expQ.size() != 0) begin
            errors++;
            $display("%0d expected writes never appeared on the output", expQ.size());
        end
        errors += UUT.props.failCount;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/mipsCore_properties.sv */
`default_nettype none

module mipsCore_properties (
    input logic          Clk,
    input logic          Rst,
    input logic          InstrValid,
    input cpuPkg::instrT Instr,
    input logic          WbValid,
    input cpuPkg::wbT    Wb
);
    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;

    // True for a supported opcode with a nonzero destination
    function automatic logic expectsWrite(cpuPkg::instrT ins);
        cpuPkg::opCodeT op;
        logic           toRd;
        op   = ins[31:26];
        toRd = (op == cpuPkg::OpRType) || (op == cpuPkg::OpSpecial2) || (op == cpuPkg::OpSpecial3);
        if (!(op inside {cpuPkg::OpRType, cpuPkg::OpSpecial2, cpuPkg::OpSpecial3,
                         cpuPkg::OpAddi, cpuPkg::OpAddiu, cpuPkg::OpSlti, cpuPkg::OpSltiu,
                         cpuPkg::OpAndi, cpuPkg::OpOri, cpuPkg::OpXori})) begin
            return 1'b0;
        end
        return toRd ? (ins[15:11] != '0) : (ins[20:16] != '0);
    endfunction

    //////////////////////////////////////////////////
    // Strobe timing
    //////////////////////////////////////////////////
    strobeAfterWrite: assert property (@(posedge Clk) disable iff (Rst)
        (InstrValid && expectsWrite(Instr)) |=> WbValid)
        else begin
            failCount++;
            $error("WbValid missing one cycle after a writing instruction");
        end

    noStrayStrobe: assert property (@(posedge Clk) disable iff (Rst)
        !(InstrValid && expectsWrite(Instr)) |=> !WbValid)
        else begin
            failCount++;
            $error("WbValid raised without a writing instruction");
        end

    noRegZeroWrite: assert property (@(posedge Clk) WbValid |-> (Wb.dest != '0))
        else begin
            failCount++;
            $error("WbValid raised for register 0");
        end

    // Quiet in reset and in the cycle after release
    resetQuiet: assert property (@(posedge Clk) (Rst || $fell(Rst)) |-> !WbValid)
        else begin
            failCount++;
            $error("WbValid high around reset");
        end

endmodule

bind mipsCore mipsCore_properties props (.Clk, .Rst, .InstrValid, .Instr, .WbValid, .Wb);

`default_nettype wire
